//--- Bender.yml
package:
  name: seq_top

sources:
  - files:
      - rtl/seq_isa_pkg.sv
      - rtl/seq_ctrl_pkg.sv
      - rtl/seq_apb_regs.sv
      - rtl/seq_fetch.sv
      - rtl/seq_decode.sv
      - rtl/seq_exec_pipe.sv
      - rtl/seq_prefix_result.sv
      - rtl/seq_top.sv
  - target: test
    files:
      - bench/seq_top_sva.sv
      - bench/tb_seq_top.sv

//--- bench/seq_top_sva.sv
// ******************************
// bound into seq_top, sampled on the rising clock edge
// all checks are off while rst_n is low
// ******************************
module seq_top_sva (
  input logic clk,
  input logic rst_n,
  input logic fe_rd,
  input logic pf_full,
  input logic pf_valid,
  input logic penable,
  input logic pslverr
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  // no frame starts without room in the prefix FIFO
  a_start_needs_room: assert property (@(posedge clk) disable iff (!rst_n) fe_rd |-> !pf_full)
    else begin
      $error("fe_rd asserted while pf_full is high");
      fail_count++;
    end

  // write strobe lasts one cycle
  a_single_write: assert property (@(posedge clk) disable iff (!rst_n) pf_valid |=> !pf_valid)
    else begin
      $error("pf_valid high for two cycles in a row");
      fail_count++;
    end

  a_err_in_access: assert property (@(posedge clk) disable iff (!rst_n) pslverr |-> penable)
    else begin
      $error("pslverr raised outside the access phase");
      fail_count++;
    end

endmodule

bind seq_top seq_top_sva u_sva (.*);

//--- bench/tb_seq_top.sv
// ******************************
// directed tests, every program ends in HALT
// the run stops at the first mismatch
// ******************************
module tb_seq_top;
  timeunit 1ns;
  timeprecision 100ps;
  import seq_isa_pkg::*;
  import seq_ctrl_pkg::*;

  localparam int PC_W        = 8;
  localparam int N_NEURON    = 128;
  localparam int N_OUT       = 64;
  // stage 0 to stage 7 plus the write cycle and one spare
  localparam int PIPE_DEPTH  = 10;
  localparam int N_TESTS     = 6;
  localparam int TEST_CYCLES = 300;
  localparam int MAX_CYCLES  = N_TESTS * TEST_CYCLES + 1200;

  logic                clk;
  logic                rst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [7:0]          paddr;
  logic [31:0]         pwdata;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;
  logic [3:0]          fe_empty;
  logic                fe_rd;
  logic [PC_W-1:0]     im_addr;
  inst_word_u          im_data;
  logic                pf_full;
  logic [5:0]          do_prefix;
  logic                pf_valid;
  prefix_word_t        pf_data;
  logic [6:0]          ct_ptr;
  logic [6:0]          sat_ptr;
  logic [1:0]          drsel;
  logic [N_NEURON-1:0] neuron_en4;
  logic [N_OUT-1:0]    neuron_en5;
  logic [7:0]          neuron_cnt5;
  logic                ld_lr0;
  logic                ld_lr1;
  logic signed [7:0]   threshold;

  inst_word_u          imem [0:(1 << PC_W) - 1];
  int                  cycles = 0;
  int                  pf_count = 0;
  int                  lr0_count = 0;
  int                  lr1_count = 0;
  logic [N_NEURON-1:0] en4_seen = '1;
  logic [N_OUT-1:0]    en5_seen = '1;
  logic [7:0]          cnt5_seen = 8'(N_NEURON);
  int unsigned         init_seed;

  seq_top #(
    .PC_W    (PC_W),
    .N_NEURON(N_NEURON),
    .N_OUT   (N_OUT)
  ) DUT (.*);

  // instruction memory reads combinationally
  assign im_data = imem[im_addr];

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ******************************
  // monitors and timeout
  // ******************************
  always @(negedge clk) begin
    if (pf_valid) pf_count++;
    if (ld_lr0) lr0_count++;
    if (ld_lr1) lr1_count++;
    // last mask that differs from the full default count
    if (neuron_en4 != '1) en4_seen = neuron_en4;
    if (neuron_en5 != '1) en5_seen = neuron_en5;
    if (neuron_cnt5 != 8'(N_NEURON)) cnt5_seen = neuron_cnt5;
    if (DUT.u_sva.fail_count != 0) begin
      abort_run("an assertion bound to seq_top failed");
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      abort_run($sformatf("timeout, DUT still busy after %0d cycles", MAX_CYCLES));
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_prefix(input string name, input prefix_word_t got,
                              input prefix_word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR @%0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR @%0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR @%0t: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR @%0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_mask(input string name, input logic [N_NEURON-1:0] got,
                            input logic [N_NEURON-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR @%0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("ERROR @%0t: %s = %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  // ******************************
  // APB and frame helpers
  // ******************************
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    // no wait states, the access phase always completes
    check_bit("pready", pready, 1'b1);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused_rd;
    apb_access(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, 32'd0, data, err);
  endtask

  function automatic inst_word_u act_word(input logic [3:0] op, input logic [7:0] ncnt,
                                          input logic [7:0] thr, input logic lr);
    inst_word_u w;
    w                = '0;
    w.act.opcode     = op;
    w.act.ncnt_shift = ncnt;
    w.act.threshold  = thr;
    w.act.lr_sel     = lr;
    return w;
  endfunction

  function automatic inst_word_u mac_word(input logic [6:0] ct, input logic [6:0] sat,
                                          input logic [1:0] sel);
    inst_word_u w;
    w             = '0;
    w.mac.opcode  = MAC;
    w.mac.ct_ptr  = ct;
    w.mac.sat_ptr = sat;
    w.mac.drsel   = sel;
    return w;
  endfunction

  function automatic prefix_word_t expect_word(input logic is_err, input logic [7:0] code);
    prefix_word_t p;
    p.is_err = is_err;
    p.code   = code;
    return p;
  endfunction

  // NOP everywhere, address in the low bits
  task automatic clear_program();
    for (int a = 0; a < (1 << PC_W); a++) begin
      imem[a] = inst_word_u'({2'b00, NOP, 10'd0, 8'(a)});
    end
  endtask

  task automatic run_frame();
    fe_empty = 4'h0;
    @(negedge clk);
    while (!fe_rd) @(negedge clk);
    @(posedge clk);
    #1;
    fe_empty = 4'hF;
  endtask

  task automatic wait_write();
    @(negedge clk);
    while (!pf_valid) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic drain_pipe();
    repeat (PIPE_DEPTH) @(posedge clk);
    #1;
  endtask

  // ******************************
  // directed tests
  // ******************************
  task automatic regs_access();
    logic [31:0] rd;
    logic        err;
    status_t     exp_st;
    exp_st         = '0;
    exp_st.running = 1'b0;
    exp_st.pc      = 8'd0;
    apb_write(REG_CTRL, 32'd1, err);
    check_bit("pslverr", err, 1'b0);
    apb_read(REG_CTRL, rd, err);
    check_bit("sw_en", rd[0], 1'b1);
    apb_read(REG_STATUS, rd, err);
    check_status("status", status_t'(rd), exp_st);
    apb_write(8'h10, 32'd0, err);
    check_bit("pslverr", err, 1'b1);
    apb_read(8'h10, rd, err);
    check_bit("pslverr", err, 1'b1);
    apb_read(REG_CTRL, rd, err);
    check_bit("sw_en", rd[0], 1'b1);
  endtask

  task automatic normal_frame();
    logic [7:0]          ncnt;
    logic [N_NEURON-1:0] exp_mask;
    logic [N_NEURON-1:0] exp_mask5;
    int                  pf_base;
    int                  lr0_base;
    int                  lr1_base;
    ncnt = 8'd20;
    for (int i = 0; i < N_NEURON; i++) exp_mask[i] = (i < ncnt);
    for (int i = 0; i < N_NEURON; i++) exp_mask5[i] = (i < N_OUT) && (i < ncnt);
    clear_program();
    imem[0]   = act_word(SETNCNT, ncnt, 8'd0, 1'b0);
    imem[1]   = act_word(RELUS, 8'd0, 8'd0, 1'b1);
    imem[2]   = act_word(RELUP, 8'd0, -8'sd5, 1'b0);
    imem[3]   = act_word(HALT, 8'd0, 8'd0, 1'b0);
    do_prefix = 6'($urandom);
    pf_base   = pf_count;
    lr0_base  = lr0_count;
    lr1_base  = lr1_count;
    run_frame();
    wait_write();
    check_prefix("pf_data", pf_data, expect_word(1'b0, {2'b00, do_prefix}));
    drain_pipe();
    check_count("pf_valid pulses", pf_count - pf_base, 1);
    check_mask("neuron_en4", en4_seen, exp_mask);
    check_mask("neuron_en5", N_NEURON'(en5_seen), exp_mask5);
    check_byte("neuron_cnt5", cnt5_seen, ncnt);
    check_byte("threshold", threshold, 8'hFB);
    check_count("ld_lr1 pulses", lr1_count - lr1_base, 1);
    check_count("ld_lr0 pulses", lr0_count - lr0_base, 0);
  endtask

  task automatic mac_pointers();
    clear_program();
    imem[0]   = mac_word(7'h2A, 7'h15, 2'b10);
    imem[1]   = act_word(RELUP, 8'd0, 8'd3, 1'b0);
    imem[2]   = act_word(HALT, 8'd0, 8'd0, 1'b0);
    do_prefix = 6'($urandom);
    run_frame();
    wait_write();
    check_prefix("pf_data", pf_data, expect_word(1'b0, {2'b00, do_prefix}));
    check_byte("ct_ptr", {1'b0, ct_ptr}, 8'h2A);
    check_byte("sat_ptr", {1'b0, sat_ptr}, 8'h15);
    check_byte("drsel", {6'd0, drsel}, 8'h02);
    drain_pipe();
  endtask

  task automatic illegal_opcode();
    int pf_base;
    clear_program();
    imem[0] = act_word(4'd12, 8'd0, 8'd0, 1'b0);
    imem[1] = act_word(RELUP, 8'd0, 8'd0, 1'b0);
    imem[2] = act_word(HALT, 8'd0, 8'd0, 1'b0);
    pf_base = pf_count;
    run_frame();
    wait_write();
    check_prefix("pf_data", pf_data, expect_word(1'b1, ILLEGAL_OP));
    drain_pipe();
    check_count("pf_valid pulses", pf_count - pf_base, 1);
  endtask

  task automatic prefix_count_error();
    logic err;
    int   pf_base;
    clear_program();
    imem[0] = act_word(HALT, 8'd0, 8'd0, 1'b0);
    pf_base = pf_count;
    run_frame();
    wait_write();
    check_prefix("pf_data", pf_data, expect_word(1'b1, NUM_WR_ERR));
    drain_pipe();
    check_count("pf_valid pulses", pf_count - pf_base, 1);
    // disabled sequencer ignores ready buffers
    apb_write(REG_CTRL, 32'd0, err);
    pf_base  = pf_count;
    fe_empty = 4'h0;
    repeat (20) begin
      @(negedge clk);
      check_bit("fe_rd", fe_rd, 1'b0);
    end
    @(posedge clk);
    #1;
    fe_empty = 4'hF;
    check_count("pf_valid pulses", pf_count - pf_base, 0);
    apb_write(REG_CTRL, 32'd1, err);
  endtask

  task automatic back_pressure();
    int pf_base;
    clear_program();
    imem[0]   = act_word(RELUP, 8'd0, 8'd1, 1'b0);
    imem[1]   = act_word(HALT, 8'd0, 8'd0, 1'b0);
    do_prefix = 6'($urandom);
    pf_base   = pf_count;
    pf_full   = 1'b1;
    fe_empty  = 4'h0;
    repeat (20) begin
      @(negedge clk);
      check_bit("fe_rd", fe_rd, 1'b0);
    end
    @(posedge clk);
    #1;
    pf_full = 1'b0;
    run_frame();
    wait_write();
    check_prefix("pf_data", pf_data, expect_word(1'b0, {2'b00, do_prefix}));
    drain_pipe();
    check_count("pf_valid pulses", pf_count - pf_base, 1);
  endtask

  initial begin
    init_seed = 32'h4a07_f19a;
    void'($urandom(init_seed));
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = 8'd0;
    pwdata    = 32'd0;
    fe_empty  = 4'hF;
    pf_full   = 1'b0;
    do_prefix = 6'd0;
    clear_program();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    regs_access();
    normal_frame();
    mac_pointers();
    illegal_opcode();
    prefix_count_error();
    back_pressure();
    if (DUT.u_sva.fail_count != 0) begin
      abort_run("an assertion bound to seq_top failed");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- rtl/seq_apb_regs.sv
// ******************************
// pready is tied high, no wait states
// unmapped offsets answer with pslverr and change nothing
// ******************************
module seq_apb_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [7:0]            paddr,
  input  logic [31:0]           pwdata,
  input  seq_ctrl_pkg::status_t status,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  sw_en
);
  import seq_ctrl_pkg::*;

  logic access;
  logic hit_ctrl;
  logic hit_status;

  assign access     = psel && penable;
  assign hit_ctrl   = (paddr == REG_CTRL);
  assign hit_status = (paddr == REG_STATUS);

  assign pready  = 1'b1;
  assign pslverr = access && !(hit_ctrl || hit_status);

  // read mux, zero for anything unmapped
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (hit_ctrl) begin
        prdata = {31'd0, sw_en};
      end else if (hit_status) begin
        prdata = status;
      end
    end
  end

  // status is read-only, writes to it are dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sw_en <= 1'b0;
    end else if (access && pwrite && hit_ctrl) begin
      sw_en <= pwdata[0];
    end
  end

endmodule

//--- rtl/seq_ctrl_pkg.sv
// ******************************
// register map, status word and prefix FIFO word
// ******************************
package seq_ctrl_pkg;

  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_STATUS = 8'h04;

  typedef struct packed {
    logic [22:0] rsvd;
    logic        running;
    logic [7:0]  pc;
  } status_t;

  typedef enum logic [7:0] {
    PC_OVERRUN = 8'h41,
    SW_EN_ERR  = 8'h42,
    ILLEGAL_OP = 8'h43,
    NUM_WR_ERR = 8'h44
  } err_code_e;

  // code is the prefix when is_err is low
  typedef struct packed {
    logic       is_err;
    logic [7:0] code;
  } prefix_word_t;

endpackage

//--- rtl/seq_decode.sv
// ******************************
// stage 0 holds a flag-free HALT while idle
// ******************************
module seq_decode #(
  parameter int PC_W = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run,
  input  logic                    halt,
  input  logic                    sw_en,
  input  seq_isa_pkg::inst_word_u im_data,
  input  logic [PC_W-1:0]         im_addr,
  output seq_isa_pkg::stage_t     stage0,
  output logic [6:0]              ct_ptr,
  output logic [6:0]              sat_ptr,
  output logic [1:0]              drsel
);
  import seq_isa_pkg::*;

  localparam stage_t HALT_STAGE = stage_t'({2'b00, HALT, 22'd0});

  logic [3:0] op;
  logic       prefix_seen;
  err_flags_t flags;

  assign op = im_data.mac.opcode;

  // ******************************
  // per-instruction error checks
  // ******************************
  always_comb begin
    flags            = '0;
    flags.pc_overrun = (im_addr == '1);
    flags.sw_en_off  = !sw_en;
    flags.bad_opcode = !op_legal(op);
    // one prefix instruction per frame, and exactly one
    if (is_prefix_op(op)) begin
      flags.prefix_count = prefix_seen;
    end else if (op == HALT) begin
      flags.prefix_count = !prefix_seen;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage0      <= HALT_STAGE;
      prefix_seen <= 1'b0;
      ct_ptr      <= '0;
      sat_ptr     <= '0;
      drsel       <= '0;
    end else begin
      if (halt) begin
        stage0      <= HALT_STAGE;
        prefix_seen <= 1'b0;
      end else if (run) begin
        stage0 <= {im_data, flags};
        if (is_prefix_op(op)) begin
          prefix_seen <= 1'b1;
        end
      end
      // memory pointers from the word in stage 0
      if (stage0.inst.mac.opcode == MAC) begin
        ct_ptr  <= stage0.inst.mac.ct_ptr;
        sat_ptr <= stage0.inst.mac.sat_ptr;
        drsel   <= stage0.inst.mac.drsel;
      end else if (stage0.inst.mac.opcode == LOAD) begin
        ct_ptr <= stage0.inst.mac.ct_ptr;
      end
    end
  end

endmodule

//--- rtl/seq_exec_pipe.sv
// ******************************
// neuron counts are 8 bits, N_NEURON must stay below 256
// ******************************
module seq_exec_pipe #(
  parameter int N_NEURON = 128,
  parameter int N_OUT    = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  seq_isa_pkg::stage_t stage0,
  output seq_isa_pkg::stage_t stage7,
  output logic [N_NEURON-1:0] neuron_en4,
  output logic [N_OUT-1:0]    neuron_en5,
  output logic [7:0]          neuron_cnt5,
  output logic                ld_lr0,
  output logic                ld_lr1,
  output logic signed [7:0]   threshold
);
  import seq_isa_pkg::*;

  localparam logic [7:0] NCNT_INIT = 8'(N_NEURON);

  stage_t     stg [1:7];
  logic [3:0] op2;
  logic [3:0] op4;
  logic [3:0] op5;
  logic [7:0] ncnt3;
  logic [7:0] ncnt4;

  assign op2 = stg[2].inst.mac.opcode;
  assign op4 = stg[4].inst.mac.opcode;
  assign op5 = stg[5].inst.mac.opcode;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 1; k <= 7; k++) begin
        stg[k] <= '0;
      end
      ncnt3       <= NCNT_INIT;
      ncnt4       <= NCNT_INIT;
      neuron_cnt5 <= NCNT_INIT;
      ld_lr0      <= 1'b0;
      ld_lr1      <= 1'b0;
      threshold   <= '0;
    end else begin
      stg[1] <= stage0;
      for (int k = 2; k <= 7; k++) begin
        stg[k] <= stg[k-1];
      end
      // layer-3 count moves with the word into stage 3
      if (op2 == SETNCNT) begin
        ncnt3 <= stg[2].inst.act.ncnt_shift;
      end else if (op2 == HALT) begin
        ncnt3 <= NCNT_INIT;
      end
      ncnt4       <= ncnt3;
      neuron_cnt5 <= ncnt4;
      // layer register strobes
      ld_lr0 <= is_store_op(op4) && !stg[4].inst.act.lr_sel;
      ld_lr1 <= is_store_op(op4) && stg[4].inst.act.lr_sel;
      if (is_prefix_op(op5)) begin
        threshold <= stg[5].inst.act.threshold;
      end
    end
  end

  assign stage7 = stg[7];

  // ******************************
  // thermometer masks
  // ******************************
  for (genvar i = 0; i < N_NEURON; i++) begin : g_en4
    assign neuron_en4[i] = (int'(ncnt4) > i);
  end

  for (genvar i = 0; i < N_OUT; i++) begin : g_en5
    assign neuron_en5[i] = (int'(neuron_cnt5) > i);
  end

endmodule

//--- rtl/seq_fetch.sv
// ******************************
// a frame ends on HALT or when pc reaches its last address
// status.pc shows the low 8 bits of pc
// ******************************
module seq_fetch #(
  parameter int PC_W = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sw_en,
  input  logic [3:0]              fe_empty,
  input  logic                    pf_full,
  input  seq_isa_pkg::inst_word_u im_data,
  output logic                    fe_rd,
  output logic [PC_W-1:0]         im_addr,
  output logic                    run,
  output logic                    halt,
  output seq_ctrl_pkg::status_t   status
);
  import seq_isa_pkg::*;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e          state;
  state_e          state_nxt;
  logic [PC_W-1:0] pc;
  logic            frame_end;

  // all four buffers ready and room for the prefix word
  assign fe_rd     = (state == IDLE) && (fe_empty == 4'b0000) && !pf_full && sw_en;
  assign frame_end = (im_data.mac.opcode == HALT) || (pc == '1);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (fe_rd) begin
          state_nxt = RUN;
        end
      end
      RUN: begin
        if (frame_end) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      pc    <= '0;
    end else begin
      state <= state_nxt;
      // counts only while staying in RUN
      if ((state == RUN) && (state_nxt == RUN)) begin
        pc <= pc + 1'b1;
      end else begin
        pc <= '0;
      end
    end
  end

  assign im_addr = pc;
  assign run     = (state == RUN);
  assign halt    = (state == IDLE);

  always_comb begin
    status         = '0;
    status.running = run;
    status.pc      = 8'(pc);
  end

endmodule

//--- rtl/seq_isa_pkg.sv
// ******************************
// instruction word and pipeline types
// HOLD and UNLOCK keep their codes but are rejected as illegal
// ******************************
package seq_isa_pkg;

  typedef enum logic [3:0] {
    NOP      = 4'd0,
    HALT     = 4'd1,
    HOLD     = 4'd2,
    RELUS    = 4'd3,
    SIGMOIDS = 4'd4,
    SETNCNT  = 4'd5,
    RELUP    = 4'd6,
    SIGMOIDP = 4'd7,
    LOAD     = 4'd8,
    MAC      = 4'd9,
    UNLOCK   = 4'd10
  } opcode_e;

  // operand pointer view, MAC and LOAD
  typedef struct packed {
    logic [1:0] rsvd;
    logic [3:0] opcode;
    logic       pad_ct;
    logic [6:0] ct_ptr;
    logic       pad_sat;
    logic [6:0] sat_ptr;
    logic [1:0] drsel;
  } mac_view_t;

  // activation descriptor view
  typedef struct packed {
    logic [1:0]        rsvd;
    logic [3:0]        opcode;
    logic [7:0]        ncnt_shift;
    logic signed [7:0] threshold;
    logic              unused;
    logic              lr_sel;
  } act_view_t;

  typedef union packed {
    mac_view_t mac;
    act_view_t act;
  } inst_word_u;

  // highest priority first
  typedef struct packed {
    logic pc_overrun;
    logic sw_en_off;
    logic bad_opcode;
    logic prefix_count;
  } err_flags_t;

  typedef struct packed {
    inst_word_u inst;
    err_flags_t err;
  } stage_t;

  function automatic logic op_legal(logic [3:0] op);
    case (op)
      NOP, HALT, RELUS, SIGMOIDS, SETNCNT, RELUP, SIGMOIDP, LOAD, MAC: op_legal = 1'b1;
      default: op_legal = 1'b0;
    endcase
  endfunction

  function automatic logic is_prefix_op(logic [3:0] op);
    is_prefix_op = (op == RELUP) || (op == SIGMOIDP);
  endfunction

  function automatic logic is_store_op(logic [3:0] op);
    is_store_op = (op == RELUS) || (op == SIGMOIDS);
  endfunction

endpackage

//--- rtl/seq_prefix_result.sv
// ******************************
// one prefix FIFO write per frame, re-armed by HALT
// ******************************
module seq_prefix_result (
  input  logic                       clk,
  input  logic                       rst_n,
  input  seq_isa_pkg::stage_t        stage7,
  input  logic [5:0]                 do_prefix,
  output logic                       pf_valid,
  output seq_ctrl_pkg::prefix_word_t pf_data
);
  import seq_isa_pkg::*;
  import seq_ctrl_pkg::*;

  logic [3:0]   op7;
  logic         written;
  logic         wr_now;
  prefix_word_t wr_word;

  assign op7 = stage7.inst.mac.opcode;

  // error codes by flag priority, else the prefix itself
  always_comb begin
    wr_word        = '0;
    wr_word.is_err = 1'b1;
    wr_now         = !written;
    if (stage7.err.pc_overrun) begin
      wr_word.code = PC_OVERRUN;
    end else if (stage7.err.sw_en_off) begin
      wr_word.code = SW_EN_ERR;
    end else if (stage7.err.bad_opcode) begin
      wr_word.code = ILLEGAL_OP;
    end else if (stage7.err.prefix_count) begin
      wr_word.code = NUM_WR_ERR;
    end else if (is_prefix_op(op7)) begin
      wr_word.is_err = 1'b0;
      wr_word.code   = {2'b00, do_prefix};
    end else begin
      wr_now = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      written  <= 1'b0;
      pf_valid <= 1'b0;
    end else begin
      pf_valid <= wr_now;
      if (wr_now) begin
        written <= 1'b1;
      end else if (op7 == HALT) begin
        written <= 1'b0;
      end
    end
  end

  // held until the next write
  always_ff @(posedge clk) begin
    if (wr_now) begin
      pf_data <= wr_word;
    end
  end

endmodule

//--- rtl/seq_top.sv
// ******************************
// instruction memory data must be combinational from im_addr
// ******************************
module seq_top #(
  parameter int PC_W     = 8,
  parameter int N_NEURON = 128,
  parameter int N_OUT    = 64
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // APB register port
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [7:0]                 paddr,
  input  logic [31:0]                pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  // feature extractor buffers
  input  logic [3:0]                 fe_empty,
  output logic                       fe_rd,
  // instruction memory
  output logic [PC_W-1:0]            im_addr,
  input  seq_isa_pkg::inst_word_u    im_data,
  // prefix FIFO
  input  logic                       pf_full,
  input  logic [5:0]                 do_prefix,
  output logic                       pf_valid,
  output seq_ctrl_pkg::prefix_word_t pf_data,
  // datapath controls
  output logic [6:0]                 ct_ptr,
  output logic [6:0]                 sat_ptr,
  output logic [1:0]                 drsel,
  output logic [N_NEURON-1:0]        neuron_en4,
  output logic [N_OUT-1:0]           neuron_en5,
  output logic [7:0]                 neuron_cnt5,
  output logic                       ld_lr0,
  output logic                       ld_lr1,
  output logic signed [7:0]          threshold
);
  import seq_isa_pkg::*;
  import seq_ctrl_pkg::*;

  logic    sw_en;
  logic    run;
  logic    halt;
  status_t status;
  stage_t  stage0;
  stage_t  stage7;

  seq_apb_regs u_regs (.*);

  seq_fetch #(
    .PC_W(PC_W)
  ) u_fetch (.*);

  seq_decode #(
    .PC_W(PC_W)
  ) u_decode (.*);

  seq_exec_pipe #(
    .N_NEURON(N_NEURON),
    .N_OUT   (N_OUT)
  ) u_exec (.*);

  seq_prefix_result u_result (.*);

endmodule

//--- vlog.f
rtl/seq_isa_pkg.sv
rtl/seq_ctrl_pkg.sv
rtl/seq_apb_regs.sv
rtl/seq_fetch.sv
rtl/seq_decode.sv
rtl/seq_exec_pipe.sv
rtl/seq_prefix_result.sv
rtl/seq_top.sv
bench/seq_top_sva.sv
bench/tb_seq_top.sv
